// File: basic_organ.f
rtl/organ_pkg.sv
rtl/tone_generator.sv
rtl/key_command_source.sv
rtl/command_fifo.sv
rtl/speed_control.sv
rtl/basic_organ.sv
test/basic_organ_checker.sv
test/basic_organ_properties.sv
test/basic_organ_tb.sv

// File: Makefile
# Verilator build and run for the basic organ testbench

VERILATOR    ?= verilator
TOP          ?= basic_organ_tb
FILELIST     ?= basic_organ.f
BUILD_DIR    ?= obj_dir
LOG          ?= sim.log
FAIL_PATTERN ?= TB FAILED
VFLAGS       ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_PATTERN)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/basic_organ_tb.sv
`timescale 1ns/1ns
`default_nettype none

module basic_organ_tb;

  typedef enum logic [2:0] {
    act_reset_vals,
    act_note,
    act_tone,
    act_mute,
    act_key,
    act_hold
  } act_e;

  // Key masks: bit 0 up, bit 1 down, bit 2 reset
  typedef struct packed {
    act_e        act;
    logic [2:0]  arg;
    logic [15:0] hold;
    logic [15:0] expected;
  } row_t;

  logic        CLK_50M;
  logic        rst_n;
  logic [2:0]  note_sel;
  logic        audio_en;
  logic        key_up_n;
  logic        key_down_n;
  logic        key_reset_n;
  logic [7:0]  audio_sample;
  logic [15:0] freq_bcd;
  logic [15:0] sample_count;

  // ========================================
  // Stimulus table
  // ========================================

  row_t rows [25] = '{
    '{act_reset_vals, 3'd0, 16'd0, 16'd12499},
    '{act_note, 3'd0, 16'd0, 16'h0523},
    '{act_note, 3'd1, 16'd0, 16'h0587},
    '{act_note, 3'd2, 16'd0, 16'h0659},
    '{act_note, 3'd3, 16'd0, 16'h0698},
    '{act_note, 3'd4, 16'd0, 16'h0783},
    '{act_note, 3'd5, 16'd0, 16'h0880},
    '{act_note, 3'd6, 16'd0, 16'h0987},
    '{act_note, 3'd7, 16'd0, 16'h1046},
    '{act_tone, 3'd0, 16'd0, 16'hBAB9},
    '{act_tone, 3'd1, 16'd0, 16'hA65D},
    '{act_tone, 3'd2, 16'd0, 16'h9430},
    '{act_tone, 3'd3, 16'd0, 16'h8BE8},
    '{act_tone, 3'd4, 16'd0, 16'h7CB8},
    '{act_tone, 3'd5, 16'd0, 16'h6EF9},
    '{act_tone, 3'd6, 16'd0, 16'h62F1},
    '{act_tone, 3'd7, 16'd0, 16'h5D5D},
    '{act_mute, 3'd7, 16'd0, 16'h5D5D},
    '{act_key, 3'b001, 16'd8, 16'd12599},
    '{act_key, 3'b001, 16'd8, 16'd12699},
    '{act_key, 3'b100, 16'd8, 16'd12499},
    '{act_key, 3'b010, 16'd8, 16'd12399},
    '{act_key, 3'b010, 16'd8, 16'd12299},
    '{act_key, 3'b101, 16'd8, 16'd12499},
    // Expected column is the minimum number of steps here
    '{act_hold, 3'b001, 16'd400, 16'd4}
  };

  basic_organ #(
    .REPEAT_CYCLES (32'd60)
  ) uut (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .note_sel     (note_sel),
    .audio_en     (audio_en),
    .key_up_n     (key_up_n),
    .key_down_n   (key_down_n),
    .key_reset_n  (key_reset_n),
    .audio_sample (audio_sample),
    .freq_bcd     (freq_bcd),
    .sample_count (sample_count)
  );

  basic_organ_checker chk (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .audio_sample (audio_sample),
    .freq_bcd     (freq_bcd),
    .sample_count (sample_count)
  );

  initial CLK_50M = 1'b0;
  always #10 CLK_50M = ~CLK_50M;

  // Keys are active low
  task automatic press_keys(input logic [2:0] mask, input logic [15:0] hold);
    key_up_n    = ~mask[0];
    key_down_n  = ~mask[1];
    key_reset_n = ~mask[2];
    repeat (hold) @(posedge CLK_50M);
    #2;
    key_up_n    = 1'b1;
    key_down_n  = 1'b1;
    key_reset_n = 1'b1;
  endtask

  task automatic apply_row(input row_t r);
    @(posedge CLK_50M);
    #2;
    case (r.act)
      act_reset_vals:
        chk.check_reset(r.expected);
      act_note:
      begin
        note_sel = r.arg;
        chk.check_freq(r.expected);
      end
      act_tone:
      begin
        note_sel = r.arg;
        audio_en = 1'b1;
        chk.check_tone(r.expected);
      end
      act_mute:
      begin
        note_sel = r.arg;
        audio_en = 1'b0;
        chk.check_silent(r.expected);
      end
      act_key:
      begin
        press_keys(r.arg, r.hold);
        chk.expect_step(r.arg, r.expected);
      end
      default:
      begin
        press_keys(r.arg, r.hold);
        chk.check_held(r.expected);
      end
    endcase
  endtask

  // ========================================
  // Main sequence
  // ========================================

  initial
  begin
    int gap;
    void'($urandom(32'hd750_69dd));
    rst_n       = 1'b0;
    note_sel    = 3'd0;
    audio_en    = 1'b0;
    key_up_n    = 1'b1;
    key_down_n  = 1'b1;
    key_reset_n = 1'b1;
    repeat (16) @(posedge CLK_50M);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < $size(rows); i++)
    begin
      apply_row(rows[i]);
      gap = 4 + int'($urandom % 16);
      repeat (gap) @(posedge CLK_50M);
    end
    $display("Done: %0d value errors, %0d other failures, %0d assertion failures",
             chk.value_errors, chk.other_errors, uut.cmd_fifo.props.fail_count);
    if (chk.value_errors + chk.other_errors + uut.cmd_fifo.props.fail_count == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/basic_organ_properties.sv
`timescale 1ns/1ns
`default_nettype none

module basic_organ_properties (
  input wire logic                 CLK_50M,
  input wire logic                 rst_n,
  input wire logic                 cmd_req,
  input wire logic                 cmd_ack,
  input wire organ_pkg::speed_op_e cmd_op,
  input wire logic                 out_req,
  input wire logic                 out_ack,
  input wire organ_pkg::speed_op_e out_op,
  input wire logic                 full
);

  int fail_count = 0;

  // Requests are held until the responder acks
  a_cmd_req_held: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    cmd_req && !cmd_ack |=> cmd_req)
  else
  begin
    fail_count++;
    $error("cmd_req dropped before cmd_ack");
  end

  a_out_req_held: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    out_req && !out_ack |=> out_req)
  else
  begin
    fail_count++;
    $error("out_req dropped before out_ack");
  end

  // Opcodes frozen while a request is up
  a_cmd_op_stable: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    cmd_req && $past(cmd_req) |-> $stable(cmd_op))
  else
  begin
    fail_count++;
    $error("cmd_op changed while cmd_req was high");
  end

  a_out_op_stable: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    out_req && $past(out_req) |-> $stable(out_op))
  else
  begin
    fail_count++;
    $error("out_op changed while out_req was high");
  end

  // No ack is given while every entry is taken
  a_no_push_full: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    full && !cmd_ack |=> !cmd_ack)
  else
  begin
    fail_count++;
    $error("push into a full command FIFO");
  end

endmodule

bind command_fifo basic_organ_properties props (
  .CLK_50M (CLK_50M),
  .rst_n   (rst_n),
  .cmd_req (cmd_req),
  .cmd_ack (cmd_ack),
  .cmd_op  (cmd_op),
  .out_req (out_req),
  .out_ack (out_ack),
  .out_op  (out_op),
  .full    (full)
);

`default_nettype wire

// File: test/basic_organ_checker.sv
`timescale 1ns/1ns
`default_nettype none

module basic_organ_checker (
  input wire logic        CLK_50M,
  input wire logic        rst_n,
  input wire logic [7:0]  audio_sample,
  input wire logic [15:0] freq_bcd,
  input wire logic [15:0] sample_count
);

  int          value_errors = 0;
  int          other_errors = 0;
  int          cycle = 0;
  logic [15:0] model = organ_pkg::default_sample_count;
  logic [15:0] last_count;
  logic [15:0] chg_vals [$];
  int          chg_cycles [$];

  // ========================================
  // sample_count change recorder
  // ========================================

  always @(negedge CLK_50M)
  begin
    cycle = cycle + 1;
    if (rst_n && sample_count !== last_count)
    begin
      chg_vals.push_back(sample_count);
      chg_cycles.push_back(cycle);
    end
    last_count = sample_count;
  end

  task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("ERR %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    other_errors++;
    $display("Check failed: %s", what);
  endtask

  task automatic check_reset(input logic [15:0] exp_count);
    @(negedge CLK_50M);
    compare("audio_sample", {8'h00, audio_sample}, 16'h0080);
    compare("sample_count", sample_count, exp_count);
    compare("freq_bcd", freq_bcd, 16'h0523);
  endtask

  // Registered one cycle after the note changes
  task automatic check_freq(input logic [15:0] exp);
    @(posedge CLK_50M);
    @(negedge CLK_50M);
    compare("freq_bcd", freq_bcd, exp);
  endtask

  // ========================================
  // Tone checks
  // ========================================

  task automatic wait_toggle(input int limit, output int cycles);
    logic [7:0] start;
    start = audio_sample;
    cycles = 0;
    do
    begin
      @(negedge CLK_50M);
      cycles++;
      if (audio_sample !== 8'h7F && audio_sample !== 8'h80)
      begin
        value_errors++;
        $display("ERR audio_sample: got 0x%h expected 0x7f or 0x80", audio_sample);
      end
    end
    while (audio_sample === start && cycles < limit);
    if (audio_sample === start)
      report_failure("audio_sample did not toggle in time");
  endtask

  task automatic check_tone(input logic [15:0] half);
    int n;
    int limit;
    limit = 2 * int'(half) + 16;
    @(negedge CLK_50M);
    // First interval follows the note restart and is not measured
    wait_toggle(limit, n);
    repeat (2)
    begin
      wait_toggle(limit, n);
      if (n != int'(half))
      begin
        value_errors++;
        $display("ERR audio_sample half period: got 0x%h expected 0x%h", n, half);
      end
    end
  endtask

  task automatic check_silent(input logic [15:0] half);
    bit bad;
    bad = 1'b0;
    repeat (3) @(negedge CLK_50M);
    for (int i = 0; i < 2 * int'(half) && !bad; i++)
    begin
      @(negedge CLK_50M);
      if (audio_sample !== 8'h80)
      begin
        bad = 1'b1;
        compare("audio_sample", {8'h00, audio_sample}, 16'h0080);
      end
    end
  endtask

  // ========================================
  // Speed checks
  // ========================================

  task automatic expect_step(input logic [2:0] keys, input logic [15:0] exp);
    logic [15:0] next;
    int          waited;
    // Reset wins, then up, then down
    if (keys[2])
      model = organ_pkg::default_sample_count;
    else if (keys[0])
      model = model + $unsigned(organ_pkg::speed_step);
    else if (keys[1])
      model = model - $unsigned(organ_pkg::speed_step);
    if (model !== exp)
      report_failure("stimulus table disagrees with the speed model");
    waited = 0;
    while (chg_vals.size() == 0 && waited < 60)
    begin
      @(posedge CLK_50M);
      waited++;
    end
    if (chg_vals.size() == 0)
      report_failure("timeout waiting for sample_count to change");
    else
    begin
      next = chg_vals.pop_front();
      void'(chg_cycles.pop_front());
      compare("sample_count", next, model);
    end
  endtask

  task automatic check_held(input logic [15:0] min_changes);
    int          n;
    int          c;
    int          prev_cycle;
    logic [15:0] v;
    n = 0;
    prev_cycle = 0;
    // Let the last repeat drain through the FIFO
    repeat (40) @(posedge CLK_50M);
    while (chg_vals.size() > 0)
    begin
      v = chg_vals.pop_front();
      c = chg_cycles.pop_front();
      model = model + $unsigned(organ_pkg::speed_step);
      compare("sample_count", v, model);
      if (n > 0 && c - prev_cycle < 60)
        report_failure("repeated steps came less than 60 cycles apart");
      prev_cycle = c;
      n++;
    end
    if (n < int'(min_changes))
      report_failure($sformatf("held key gave %0d steps, wanted %0d", n, min_changes));
    repeat (200) @(posedge CLK_50M);
    if (chg_vals.size() != 0)
      report_failure("sample_count moved after the key was released");
  endtask

endmodule

`default_nettype wire

// File: rtl/basic_organ.sv
`timescale 1ns/1ns
`default_nettype none

module basic_organ #(
  parameter logic [31:0] REPEAT_CYCLES = organ_pkg::default_repeat_cycles
) (
  input  wire logic                 CLK_50M,
  input  wire logic                 rst_n,
  input  wire organ_pkg::note_sel_t note_sel,
  input  wire logic                 audio_en,
  input  wire logic                 key_up_n,
  input  wire logic                 key_down_n,
  input  wire logic                 key_reset_n,
  output organ_pkg::sample_t        audio_sample,
  output logic [15:0]               freq_bcd,
  output logic [15:0]               sample_count
);

  // Speed command path
  logic                 cmd_req;
  logic                 cmd_ack;
  organ_pkg::speed_op_e cmd_op;
  logic                 out_req;
  logic                 out_ack;
  organ_pkg::speed_op_e out_op;

  tone_generator tone_gen (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .note_sel     (note_sel),
    .audio_en     (audio_en),
    .audio_sample (audio_sample),
    .freq_bcd     (freq_bcd)
  );

  key_command_source #(
    .REPEAT_CYCLES (REPEAT_CYCLES)
  ) key_src (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .key_up_n    (key_up_n),
    .key_down_n  (key_down_n),
    .key_reset_n (key_reset_n),
    .cmd_req     (cmd_req),
    .cmd_op      (cmd_op),
    .cmd_ack     (cmd_ack)
  );

  command_fifo cmd_fifo (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .cmd_req (cmd_req),
    .cmd_op  (cmd_op),
    .cmd_ack (cmd_ack),
    .out_req (out_req),
    .out_op  (out_op),
    .out_ack (out_ack)
  );

  speed_control speed_ctl (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .out_req      (out_req),
    .out_op       (out_op),
    .out_ack      (out_ack),
    .sample_count (sample_count)
  );

endmodule

`default_nettype wire

// File: rtl/speed_control.sv
`timescale 1ns/1ns
`default_nettype none

module speed_control (
  input  wire logic                  CLK_50M,
  input  wire logic                  rst_n,
  input  wire logic                  out_req,
  input  wire organ_pkg::speed_op_e  out_op,
  output logic                       out_ack,
  output logic [15:0]                sample_count
);

  organ_pkg::speed_t speed;
  organ_pkg::speed_t speed_next;
  logic              accept;

  // New request seen while ack is still low
  assign accept = out_req && !out_ack;

  always_comb
  begin
    case (out_op)
      organ_pkg::op_up:    speed_next = speed + organ_pkg::speed_step;
      organ_pkg::op_down:  speed_next = speed - organ_pkg::speed_step;
      organ_pkg::op_reset: speed_next = '0;
      default:             speed_next = speed;
    endcase
  end

  // ========================================
  // Speed register and sampling count
  // ========================================

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      out_ack      <= 1'b0;
      speed        <= '0;
      sample_count <= organ_pkg::default_sample_count;
    end
    else if (accept)
    begin
      // Update lands on the same edge as the ack
      out_ack      <= 1'b1;
      speed        <= speed_next;
      sample_count <= organ_pkg::default_sample_count + $unsigned(speed_next);
    end
    else if (!out_req)
    begin
      out_ack <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/command_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module command_fifo (
  input  wire logic                  CLK_50M,
  input  wire logic                  rst_n,
  input  wire logic                  cmd_req,
  input  wire organ_pkg::speed_op_e  cmd_op,
  output logic                       cmd_ack,
  output logic                       out_req,
  output organ_pkg::speed_op_e       out_op,
  input  wire logic                  out_ack
);

  organ_pkg::speed_op_e   mem [organ_pkg::fifo_depth];
  organ_pkg::fifo_ptr_t   wr_ptr;
  organ_pkg::fifo_ptr_t   rd_ptr;
  organ_pkg::fifo_count_t count;
  logic                   full;
  logic                   empty;
  logic                   push;
  logic                   pop;
  logic                   launch;

  assign full  = (count == organ_pkg::fifo_count_t'(organ_pkg::fifo_depth));
  assign empty = (count == '0);

  // Take a new request only while an entry is free
  assign push = cmd_req && !cmd_ack && !full;
  // Pop once the consumer has taken the head
  assign pop = out_req && out_ack;
  // Present the head after the previous ack has dropped
  assign launch = !out_req && !out_ack && !empty;

  // ========================================
  // Storage and pointers
  // ========================================

  always_ff @(posedge CLK_50M)
  begin
    if (push)
      mem[wr_ptr] <= cmd_op;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // Slave side, ack follows req
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      cmd_ack <= 1'b0;
    else if (push)
      cmd_ack <= 1'b1;
    else if (!cmd_req)
      cmd_ack <= 1'b0;
  end

  // Master side
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      out_req <= 1'b0;
    else if (launch)
    begin
      out_req <= 1'b1;
      out_op  <= mem[rd_ptr];
    end
    else if (pop)
      out_req <= 1'b0;
  end

endmodule

`default_nettype wire

// File: rtl/key_command_source.sv
`timescale 1ns/1ns
`default_nettype none

module key_command_source #(
  parameter logic [31:0] REPEAT_CYCLES = organ_pkg::default_repeat_cycles
) (
  input  wire logic              CLK_50M,
  input  wire logic              rst_n,
  input  wire logic              key_up_n,
  input  wire logic              key_down_n,
  input  wire logic              key_reset_n,
  output logic                   cmd_req,
  output organ_pkg::speed_op_e   cmd_op,
  input  wire logic              cmd_ack
);

  typedef enum logic [1:0] {
    st_idle,
    st_req_high,
    st_wait_ack_low
  } state_e;

  // Bit 0 up, bit 1 down, bit 2 reset, all active high here
  logic [2:0]           key_meta;
  logic [2:0]           key_sync;
  logic [2:0]           key_prev;
  logic [2:0]           key_press;
  logic [31:0]          rep_cnt;
  logic                 rep_tick;
  logic                 hold_updown;
  logic                 event_valid;
  organ_pkg::speed_op_e event_op;
  state_e               state;

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      key_meta <= '0;
      key_sync <= '0;
      key_prev <= '0;
    end
    else
    begin
      key_meta <= ~{key_reset_n, key_down_n, key_up_n};
      key_sync <= key_meta;
      key_prev <= key_sync;
    end
  end

  assign key_press = key_sync & ~key_prev;

  // Repeats only for up or down, and not while reset is held
  assign hold_updown = (key_sync[0] | key_sync[1]) & ~key_sync[2];
  assign rep_tick    = hold_updown && (rep_cnt == REPEAT_CYCLES - 32'd1);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      rep_cnt <= '0;
    else if (!hold_updown || key_press[0] || key_press[1] || rep_tick)
      rep_cnt <= '0;
    else
      rep_cnt <= rep_cnt + 32'd1;
  end

  // Reset first, then up, then down
  always_comb
  begin
    event_valid = 1'b1;
    event_op    = organ_pkg::op_up;
    if (key_press[2])
      event_op = organ_pkg::op_reset;
    else if (key_press[0] || (rep_tick && key_sync[0]))
      event_op = organ_pkg::op_up;
    else if (key_press[1] || (rep_tick && key_sync[1]))
      event_op = organ_pkg::op_down;
    else
      event_valid = 1'b0;
  end

  // ========================================
  // Four-phase requester
  // ========================================

  // Events arriving outside st_idle are dropped
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state   <= st_idle;
      cmd_req <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
          if (event_valid)
          begin
            cmd_op  <= event_op;
            cmd_req <= 1'b1;
            state   <= st_req_high;
          end
        st_req_high:
          if (cmd_ack)
          begin
            cmd_req <= 1'b0;
            state   <= st_wait_ack_low;
          end
        st_wait_ack_low:
          if (!cmd_ack)
            state <= st_idle;
        default:
          state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/tone_generator.sv
`timescale 1ns/1ns
`default_nettype none

module tone_generator (
  input  wire logic                 CLK_50M,
  input  wire logic                 rst_n,
  input  wire organ_pkg::note_sel_t note_sel,
  input  wire logic                 audio_en,
  output organ_pkg::sample_t        audio_sample,
  output logic [15:0]               freq_bcd
);

  organ_pkg::note_sel_t     note_q;
  organ_pkg::half_period_t  half_period;
  organ_pkg::half_period_t  div_cnt;
  logic                     wave;
  logic                     note_changed;

  // Table lookup for the selected note
  assign half_period  = organ_pkg::note_half_period[note_sel];
  assign note_changed = (note_sel != note_q);

  // ========================================
  // Square wave divider
  // ========================================

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      note_q  <= '0;
      div_cnt <= '0;
      wave    <= 1'b0;
    end
    else if (note_changed)
    begin
      // New note restarts with the wave low
      note_q  <= note_sel;
      div_cnt <= '0;
      wave    <= 1'b0;
    end
    else if (div_cnt == half_period - 16'd1)
    begin
      div_cnt <= '0;
      wave    <= ~wave;
    end
    else
    begin
      div_cnt <= div_cnt + 16'd1;
    end
  end

  // Gated sample and frequency readout
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      audio_sample <= organ_pkg::sample_low;
      freq_bcd     <= organ_pkg::note_freq_bcd[0];
    end
    else
    begin
      audio_sample <= (audio_en && wave) ? organ_pkg::sample_high : organ_pkg::sample_low;
      freq_bcd     <= organ_pkg::note_freq_bcd[note_sel];
    end
  end

endmodule

`default_nettype wire

// File: rtl/organ_pkg.sv
`default_nettype none

package organ_pkg;

  // ========================================
  // Tone tables
  // ========================================

  typedef logic [2:0] note_sel_t;
  typedef logic [15:0] half_period_t;
  typedef logic signed [7:0] sample_t;

  // Divider count per half period, DO first
  localparam half_period_t note_half_period [0:7] = '{
    16'hBAB9,
    16'hA65D,
    16'h9430,
    16'h8BE8,
    16'h7CB8,
    16'h6EF9,
    16'h62F1,
    16'h5D5D
  };

  // Note frequency in Hz as four BCD digits
  localparam logic [15:0] note_freq_bcd [0:7] = '{
    16'h0523,
    16'h0587,
    16'h0659,
    16'h0698,
    16'h0783,
    16'h0880,
    16'h0987,
    16'h1046
  };

  localparam sample_t sample_high = 8'sh7F;
  // Also the silent level
  localparam sample_t sample_low = 8'sh80;

  // ========================================
  // Speed control
  // ========================================

  typedef enum logic [1:0] {
    op_up,
    op_down,
    op_reset
  } speed_op_e;

  typedef logic signed [15:0] speed_t;

  localparam speed_t speed_step = 16'sd100;
  localparam logic [15:0] default_sample_count = 16'd12499;

  // Command FIFO geometry
  localparam int fifo_depth = 4;
  typedef logic [$clog2(fifo_depth)-1:0] fifo_ptr_t;
  typedef logic [$clog2(fifo_depth+1)-1:0] fifo_count_t;

  // Ten repeats per second at 50 MHz
  localparam logic [31:0] default_repeat_cycles = 32'd5_000_000;

endpackage

`default_nettype wire
